// File: design/mult.sv
//////////////////////////////////////////////////////////////////////
// Combinational multiply-accumulate core, result expected in a flop
// Carry-in is used only in VEC_MODE32 and VEC_MODE216
// Lane modes wrap inside each lane and give no carry
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult
  import mult_cfg_pkg::*;
  import mult_op_pkg::*;
(
  input  vec_mode_t    vector_mode_i,
  input  subword_sel_t sel_subword_i,
  input  signed_mode_t signed_mode_i,
  input  logic         use_carry_i,
  input  logic         mac_en_i,

  input  word_t        op_a_i,
  input  word_t        op_b_i,
  input  word_t        mac_i,
  input  logic         carry_i,

  output word_t        result_o,
  output logic         carry_o,
  output logic         overflow_o
);

  word_t mac_int;
  logic  carry_in;
  half_t a_half;
  half_t b_half;
  word_t op_a_sel;
  word_t op_b_sel;
  wide_t full_sum;
  word_t lane16_sum;
  word_t lane8_sum;
  wide_t result;

  // Addend is the accumulator only for MAC operations
  assign mac_int  = mac_en_i ? mac_i : '0;
  assign carry_in = use_carry_i & carry_i;

  //////////////////////////////////////////////////////////////////////
  // Subword selection and extension
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // Pick low or high half of each operand
    a_half = sel_subword_i[A_BIT] ? op_a_i[DATA_W-1 -: HALF_W] : op_a_i[HALF_W-1:0];
    b_half = sel_subword_i[B_BIT] ? op_b_i[DATA_W-1 -: HALF_W] : op_b_i[HALF_W-1:0];

    // Other modes use the operands untouched
    op_a_sel = op_a_i;
    op_b_sel = op_b_i;

    if (vector_mode_i == VEC_MODE216)
    begin
      // Sign or zero extension per operand
      op_a_sel = {{HALF_W{signed_mode_i[A_BIT] & a_half[HALF_W-1]}}, a_half};
      op_b_sel = {{HALF_W{signed_mode_i[B_BIT] & b_half[HALF_W-1]}}, b_half};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sums for each mode
  //////////////////////////////////////////////////////////////////////

  // 33-bit sum, top bit becomes the carry
  assign full_sum = wide_t'(mac_int) + wide_t'(op_a_sel) * wide_t'(op_b_sel)
                  + wide_t'(carry_in);

  always_comb
  begin
    // Each 16-bit lane wraps on its own
    for (int i = 0; i < N_LANE16; i++)
    begin
      lane16_sum[i*HALF_W +: HALF_W] = mac_int[i*HALF_W +: HALF_W]
        + op_a_sel[i*HALF_W +: HALF_W] * op_b_sel[i*HALF_W +: HALF_W];
    end

    // Same for the byte lanes
    for (int j = 0; j < N_LANE8; j++)
    begin
      lane8_sum[j*LANE8_W +: LANE8_W] = mac_int[j*LANE8_W +: LANE8_W]
        + op_a_sel[j*LANE8_W +: LANE8_W] * op_b_sel[j*LANE8_W +: LANE8_W];
    end
  end

  // Lane modes carry nothing out
  always_comb
  begin
    case (vector_mode_i)
      VEC_MODE16: result = {1'b0, lane16_sum};
      VEC_MODE8:  result = {1'b0, lane8_sum};
      default:    result = full_sum;
    endcase
  end

  assign result_o   = result[DATA_W-1:0];
  assign carry_o    = result[DATA_W];

  // Sign change between raw accumulator input and result
  assign overflow_o = mac_i[DATA_W-1] ^ result[DATA_W-1];

endmodule

// File: design/mult_acc_regs.sv
//////////////////////////////////////////////////////////////////////
// Accumulator and carry register for chained MAC operations
// Written only on the completion pulse, cleared by reset
// Holds raw core outputs, including lane results
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_acc_regs
  import mult_cfg_pkg::*;
(
  input  logic  clk,
  input  logic  reset_i,

  // Completion pulse and core outputs to store
  input  logic  done_i,
  input  word_t result_i,
  input  logic  carry_i,

  // Addend and carry toward the core
  output word_t acc_o,
  output logic  carry_o
);

  // Carry in the top bit, accumulator below
  wide_t acc_q;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      acc_q <= '0;
    end
    else if (done_i)
    begin
      // Latest result feeds the next MAC
      acc_q <= {carry_i, result_i};
    end
  end

  assign acc_o   = acc_q[DATA_W-1:0];
  assign carry_o = acc_q[DATA_W];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Stored value moves only right after a completion
  acc_stable_between_done: assert property (
    @(posedge clk) disable iff (reset_i)
    (!$past(done_i) && !$past(reset_i)) |-> $stable(acc_q)
  )
  else
    $error("accumulator changed without done_i");

endmodule

// File: design/mult_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Data widths of the execute stage multiplier
// Widths are fixed by the instruction set and are not meant to change
// The word is split into 16-bit halves and 8-bit lanes
//////////////////////////////////////////////////////////////////////

package mult_cfg_pkg;

  // Operand, result and accumulator width
  localparam int DATA_W = 32;

  // Sum width including the carry bit
  localparam int WIDE_W = DATA_W + 1;

  // Subword and 16-bit lane width
  localparam int HALF_W = 16;

  // Byte lane width
  localparam int LANE8_W = 8;

  // Lane counts in the vector modes
  localparam int N_LANE16 = DATA_W / HALF_W;
  localparam int N_LANE8  = DATA_W / LANE8_W;

  //////////////////////////////////////////////////////////////////////
  // Data vector types
  //////////////////////////////////////////////////////////////////////

  // One operand, result or accumulator value
  typedef logic [DATA_W-1:0] word_t;

  // Full width sum with the carry in the top bit
  typedef logic [WIDE_W-1:0] wide_t;

  // One selected 16-bit subword
  typedef logic [HALF_W-1:0] half_t;

endpackage

// File: design/mult_op_pkg.sv
//////////////////////////////////////////////////////////////////////
// Operation encoding of the multiplier and controller state names
// Vector mode codes follow the processor decoder
// Bit 1 of select and sign fields refers to operand A, bit 0 to B
//////////////////////////////////////////////////////////////////////

package mult_op_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector modes
  //////////////////////////////////////////////////////////////////////

  // Lane arrangement of one operation
  typedef logic [1:0] vec_mode_t;

  // Full 32-bit multiply
  localparam vec_mode_t VEC_MODE32  = 2'b00;
  // Selected 16-bit halves, extended to 32 bits
  localparam vec_mode_t VEC_MODE216 = 2'b01;
  // Two independent 16-bit lanes
  localparam vec_mode_t VEC_MODE16  = 2'b10;
  // Four independent 8-bit lanes
  localparam vec_mode_t VEC_MODE8   = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // Subword select and sign control
  //////////////////////////////////////////////////////////////////////

  // Set bit picks the high half of the operand
  typedef logic [1:0] subword_sel_t;

  // Set bit sign-extends the selected half
  typedef logic [1:0] signed_mode_t;

  // Bit positions inside the select and sign fields
  localparam int A_BIT = 1;
  localparam int B_BIT = 0;

  // Handshake controller states
  typedef enum logic [1:0]
  {
    CTRL_IDLE,
    CTRL_CALC,
    CTRL_DONE
  } ctrl_state_t;

endpackage

// File: design/mult_req_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Four-phase req/ack controller with operand and result registers
// One operation in flight, ack_o one cycle after acceptance edge
// Operands must stay valid while req_i is high and ack_o low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_req_ctrl
  import mult_cfg_pkg::*;
  import mult_op_pkg::*;
(
  input  logic         clk,
  input  logic         reset_i,

  // Issuing side
  input  logic         req_i,
  input  vec_mode_t    vector_mode_i,
  input  subword_sel_t sel_subword_i,
  input  signed_mode_t signed_mode_i,
  input  logic         use_carry_i,
  input  logic         mac_en_i,
  input  word_t        op_a_i,
  input  word_t        op_b_i,
  output logic         ack_o,
  output logic         done_o,

  // Captured operation toward the core
  output vec_mode_t    vector_mode_o,
  output subword_sel_t sel_subword_o,
  output signed_mode_t signed_mode_o,
  output logic         use_carry_o,
  output logic         mac_en_o,
  output word_t        op_a_o,
  output word_t        op_b_o,

  // Core outputs and their registered copies
  input  word_t        core_result_i,
  input  logic         core_carry_i,
  input  logic         core_overflow_i,
  output word_t        result_o,
  output logic         carry_o,
  output logic         overflow_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        accept;

  // New request taken only from idle
  assign accept = (state_q == CTRL_IDLE) && req_i;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE:
      begin
        if (accept)
          state_d = CTRL_CALC;
      end
      // Core settles within one cycle
      CTRL_CALC:
        state_d = CTRL_DONE;
      // Back-pressure, wait for req_i to drop
      CTRL_DONE:
      begin
        if (!req_i)
          state_d = CTRL_IDLE;
      end
      default:
        state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
      state_q <= CTRL_IDLE;
    else
      state_q <= state_d;
  end

  // Result capture edge ends the CALC cycle
  assign done_o = (state_q == CTRL_CALC);
  assign ack_o  = (state_q == CTRL_DONE);

  //////////////////////////////////////////////////////////////////////
  // Operand and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      vector_mode_o <= vector_mode_i;
      sel_subword_o <= sel_subword_i;
      signed_mode_o <= signed_mode_i;
      use_carry_o   <= use_carry_i;
      mac_en_o      <= mac_en_i;
      op_a_o        <= op_a_i;
      op_b_o        <= op_b_i;
    end
  end

  // Held for the whole ack_o interval
  always_ff @(posedge clk)
  begin
    if (done_o)
    begin
      result_o   <= core_result_i;
      carry_o    <= core_carry_i;
      overflow_o <= core_overflow_i;
    end
  end

  // ack_o may only come up during an open request
  ack_needs_req: assert property (
    @(posedge clk) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i)
  )
  else
    $error("ack_o rose while req_i low");

  // Accepted request pulses done_o once, at the edge where ack_o rises
  done_with_ack: assert property (
    @(posedge clk) disable iff (reset_i)
    accept |=> done_o ##1 ($rose(ack_o) && !done_o)
  )
  else
    $error("done_o pulse not aligned with rise of ack_o");

endmodule

// File: design/mult_unit_top.sv
//////////////////////////////////////////////////////////////////////
// Multiply and MAC unit of the execute stage
// Four-phase req/ack, results valid while ack_o is high
// Accumulator chains MAC operations without a register file
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_unit_top
  import mult_cfg_pkg::*;
  import mult_op_pkg::*;
(
  input  logic         clk,
  input  logic         reset_i,

  input  logic         req_i,
  input  vec_mode_t    vector_mode_i,
  input  subword_sel_t sel_subword_i,
  input  signed_mode_t signed_mode_i,
  input  logic         use_carry_i,
  input  logic         mac_en_i,
  input  word_t        op_a_i,
  input  word_t        op_b_i,

  output logic         ack_o,
  output word_t        result_o,
  output logic         carry_o,
  output logic         overflow_o
);

  // Captured operation
  vec_mode_t    vector_mode_q;
  subword_sel_t sel_subword_q;
  signed_mode_t signed_mode_q;
  logic         use_carry_q;
  logic         mac_en_q;
  word_t        op_a_q;
  word_t        op_b_q;

  // Core outputs and accumulator feedback
  word_t        core_result;
  logic         core_carry;
  logic         core_overflow;
  logic         done;
  word_t        acc;
  logic         acc_carry;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  mult_req_ctrl i_ctrl (
    .clk             (clk),
    .reset_i         (reset_i),
    .req_i           (req_i),
    .vector_mode_i   (vector_mode_i),
    .sel_subword_i   (sel_subword_i),
    .signed_mode_i   (signed_mode_i),
    .use_carry_i     (use_carry_i),
    .mac_en_i        (mac_en_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .ack_o           (ack_o),
    .done_o          (done),
    .vector_mode_o   (vector_mode_q),
    .sel_subword_o   (sel_subword_q),
    .signed_mode_o   (signed_mode_q),
    .use_carry_o     (use_carry_q),
    .mac_en_o        (mac_en_q),
    .op_a_o          (op_a_q),
    .op_b_o          (op_b_q),
    .core_result_i   (core_result),
    .core_carry_i    (core_carry),
    .core_overflow_i (core_overflow),
    .result_o        (result_o),
    .carry_o         (carry_o),
    .overflow_o      (overflow_o)
  );

  mult i_mult (
    .vector_mode_i (vector_mode_q),
    .sel_subword_i (sel_subword_q),
    .signed_mode_i (signed_mode_q),
    .use_carry_i   (use_carry_q),
    .mac_en_i      (mac_en_q),
    .op_a_i        (op_a_q),
    .op_b_i        (op_b_q),
    .mac_i         (acc),
    .carry_i       (acc_carry),
    .result_o      (core_result),
    .carry_o       (core_carry),
    .overflow_o    (core_overflow)
  );

  // Written at the same edge as the result register
  mult_acc_regs i_acc (
    .clk      (clk),
    .reset_i  (reset_i),
    .done_i   (done),
    .result_i (core_result),
    .carry_i  (core_carry),
    .acc_o    (acc),
    .carry_o  (acc_carry)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the multiplier unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mult_unit -f vlog.f \
  || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/Vtb_mult_unit)
echo "$sim_out"
echo "$sim_out" | grep -qx "All checks passed" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock of 100 ns period and active high reset
// Reset covers the first 2 rising edges and drops on a falling edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk_o,
  output logic reset_o
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD = 50;

  initial
  begin
    clk_o = 1'b0;
    forever
      #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Released away from the rising edge
  initial
  begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// File: verification/tb_mult_unit.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the multiply and MAC unit
// Inputs change on the falling edge, assertions check on the rising
// Expected values come from a model with its own accumulator copy
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mult_unit
  import mult_cfg_pkg::*;
  import mult_op_pkg::*;
();

  // Requests per test
  localparam int N_FULL    = 8;
  localparam int N_SUB     = 16;
  localparam int N_LANE    = 16;
  localparam int N_CHAIN   = 12;
  localparam int TOTAL_REQ = N_FULL + N_SUB + N_LANE + N_CHAIN;
  localparam int MAX_HOLD  = 3;
  // Idle cycle, two to ack, hold, one to drop ack, one spare
  localparam int REQ_CYCLES     = 5 + MAX_HOLD;
  localparam int TIMEOUT_CYCLES = 2 * (TOTAL_REQ * REQ_CYCLES + 2);

  logic         clk;
  logic         reset;
  logic         req;
  vec_mode_t    vector_mode;
  subword_sel_t sel_subword;
  signed_mode_t signed_mode;
  logic         use_carry;
  logic         mac_en;
  word_t        op_a;
  word_t        op_b;
  logic         ack;
  word_t        result;
  logic         carry;
  logic         overflow;

  // Model state and expected outputs of the open request
  word_t        model_acc;
  logic         model_carry;
  word_t        exp_result;
  logic         exp_carry;
  logic         exp_overflow;
  logic [31:0]  rng_state;
  int           value_errors;
  int           proto_errors;
  int           n_done;
  int           cycle_cnt;

  tb_clock_gen i_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mult_unit_top i_dut (
    .clk           (clk),
    .reset_i       (reset),
    .req_i         (req),
    .vector_mode_i (vector_mode),
    .sel_subword_i (sel_subword),
    .signed_mode_i (signed_mode),
    .use_carry_i   (use_carry),
    .mac_en_i      (mac_en),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .ack_o         (ack),
    .result_o      (result),
    .carry_o       (carry),
    .overflow_o    (overflow)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function void report_value_error(input string name, input word_t exp, input word_t got);
    value_errors++;
    $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
  endfunction

  function void report_protocol_error(input string what);
    proto_errors++;
    $display("Protocol failure at %0t ns: %s", $time, what);
  endfunction

  function void print_counts();
    $display("Requests completed %0d, value errors %0d, protocol errors %0d",
             n_done, value_errors, proto_errors);
  endfunction

  // Expected sum with carry on top, from the per-mode operation rules
  function automatic logic [WIDE_W-1:0] model_calc(input vec_mode_t mode,
      input subword_sel_t sel, input signed_mode_t sgn, input logic uc, input logic me,
      input word_t a, input word_t b);
    logic [15:0] ha;
    logic [15:0] hb;
    word_t       ea;
    word_t       eb;
    word_t       addend;
    word_t       lanes;
    logic [63:0] full;
    logic        cin;
    addend = me ? model_acc : '0;
    cin = uc & model_carry;
    ea = a;
    eb = b;
    if (mode == VEC_MODE216)
    begin
      // Upper select bit is operand A
      ha = sel[1] ? a[31:16] : a[15:0];
      hb = sel[0] ? b[31:16] : b[15:0];
      ea = sgn[1] ? {{16{ha[15]}}, ha} : {16'h0, ha};
      eb = sgn[0] ? {{16{hb[15]}}, hb} : {16'h0, hb};
    end
    full = {32'h0, ea} * {32'h0, eb} + {32'h0, addend} + {63'h0, cin};
    case (mode)
      VEC_MODE16:
      begin
        for (int i = 0; i < 2; i++)
          lanes[16*i +: 16] = addend[16*i +: 16] + a[16*i +: 16] * b[16*i +: 16];
        return {1'b0, lanes};
      end
      VEC_MODE8:
      begin
        for (int i = 0; i < 4; i++)
          lanes[8*i +: 8] = addend[8*i +: 8] + a[8*i +: 8] * b[8*i +: 8];
        return {1'b0, lanes};
      end
      default:
        return full[WIDE_W-1:0];
    endcase
  endfunction

  // One full four-phase request, called on a falling edge with ack low
  task automatic run_request(input vec_mode_t mode, input subword_sel_t sel,
                             input signed_mode_t sgn, input logic uc, input logic me,
                             input word_t a, input word_t b, input int hold);
    logic [WIDE_W-1:0] sum;
    sum = model_calc(mode, sel, sgn, uc, me, a, b);
    exp_result   = sum[DATA_W-1:0];
    exp_carry    = sum[DATA_W];
    exp_overflow = model_acc[DATA_W-1] ^ sum[DATA_W-1];
    vector_mode = mode;
    sel_subword = sel;
    signed_mode = sgn;
    use_carry   = uc;
    mac_en      = me;
    op_a        = a;
    op_b        = b;
    req         = 1'b1;
    do
      @(negedge clk);
    while (!ack);
    // Back-pressure for a few cycles
    repeat (hold) @(negedge clk);
    req = 1'b0;
    // Operands already captured, so the bus may move
    op_a = ~a;
    op_b = ~b;
    do
      @(negedge clk);
    while (ack);
    model_acc   = exp_result;
    model_carry = exp_carry;
    n_done++;
  endtask

  task automatic random_request(input vec_mode_t mode, input subword_sel_t sel,
                                input signed_mode_t sgn, input logic uc, input logic me);
    word_t a;
    word_t b;
    rng_state = xorshift32(rng_state);
    a = rng_state;
    rng_state = xorshift32(rng_state);
    b = rng_state;
    rng_state = xorshift32(rng_state);
    run_request(mode, sel, sgn, uc, me, a, b, int'(rng_state[1:0]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checking assertions
  //////////////////////////////////////////////////////////////////////

  reset_ack_low: assert property (@(posedge clk) reset |=> !ack)
  else
    report_protocol_error("ack_o not low after reset");

  // Rise exactly two samples after req first seen high
  ack_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) == ($past(req, 2) && !$past(req, 3)))
  else
    report_protocol_error("ack_o did not rise two cycles after the request");

  // Held while req stays high, dropped one cycle after req falls
  ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    $past(ack) |-> ack == $past(req))
  else
    report_protocol_error("ack_o did not follow req_i during the ack phase");

  // Checked on every ack cycle, so held values are covered too
  result_check: assert property (@(posedge clk) disable iff (reset)
    ack |-> result == exp_result)
  else
    report_value_error("result_o", exp_result, result);

  carry_check: assert property (@(posedge clk) disable iff (reset)
    ack |-> carry == exp_carry)
  else
    report_value_error("carry_o", {31'h0, exp_carry}, {31'h0, carry});

  overflow_check: assert property (@(posedge clk) disable iff (reset)
    ack |-> overflow == exp_overflow)
  else
    report_value_error("overflow_o", {31'h0, exp_overflow}, {31'h0, overflow});

  // Watchdog
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, a request never completed", cycle_cnt);
      print_counts();
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    req          = 1'b0;
    vector_mode  = VEC_MODE32;
    sel_subword  = 2'b00;
    signed_mode  = 2'b00;
    use_carry    = 1'b0;
    mac_en       = 1'b0;
    op_a         = '0;
    op_b         = '0;
    model_acc    = '0;
    model_carry  = 1'b0;
    exp_result   = '0;
    exp_carry    = 1'b0;
    exp_overflow = 1'b0;
    rng_state    = 32'd39470;
    value_errors = 0;
    proto_errors = 0;
    n_done       = 0;
    cycle_cnt    = 0;
    @(negedge reset);
    @(negedge clk);

    // Plain 32-bit products
    for (int i = 0; i < N_FULL; i++)
      random_request(VEC_MODE32, 2'b00, 2'b00, 1'b0, 1'b0);

    // Every subword select and sign combination
    for (int s = 0; s < 4; s++)
    begin
      for (int g = 0; g < 4; g++)
        random_request(VEC_MODE216, 2'(s), 2'(g), 1'b0, 1'b0);
    end

    // Lane modes, carry-in must be ignored
    for (int i = 0; i < N_LANE / 2; i++)
      random_request(VEC_MODE16, 2'b00, 2'b00, rng_state[2], rng_state[3]);
    for (int i = 0; i < N_LANE / 2; i++)
      random_request(VEC_MODE8, 2'b00, 2'b00, rng_state[2], rng_state[3]);

    // MAC chain with carry feedback
    for (int i = 0; i < N_CHAIN - 4; i++)
      random_request(VEC_MODE32, 2'b00, 2'b00, 1'b1, 1'b1);
    for (int i = 0; i < 4; i++)
      random_request(VEC_MODE216, rng_state[1:0], rng_state[3:2], 1'b1, 1'b1);

    @(negedge clk);
    if (n_done != TOTAL_REQ)
      report_protocol_error("not every request completed");
    print_counts();
    if (value_errors == 0 && proto_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: vlog.f
design/mult_cfg_pkg.sv
design/mult_op_pkg.sv
design/mult.sv
design/mult_acc_regs.sv
design/mult_req_ctrl.sv
design/mult_unit_top.sv
verification/tb_clock_gen.sv
verification/tb_mult_unit.sv
